//--- sun2_mmu.f
mmu_cfg_pkg.sv
mmu_types_pkg.sv
pmap_bus_if.sv
pmap_word_bank.sv
mmu_front.sv
mmu_check.sv
sun2_mmu.sv
tb_sun2_mmu.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
verilator --binary --timing --assert --top-module tb_sun2_mmu -f sun2_mmu.f \
      -o tb_sun2_mmu_sim \
   && ./obj_dir/tb_sun2_mmu_sim > sim.log 2>&1 ; cat sim.log \
   && grep -qx "Testbench passed" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

//--- tb_sun2_mmu.sv
// Maps start undefined, so only entries written by the table are translated or read back
`timescale 1ns/1ps
`default_nettype none

module tb_sun2_mmu;

   localparam logic [1:0] OP_IDLE = 2'd0;
   localparam logic [1:0] OP_XLAT = 2'd1;
   localparam logic [1:0] OP_RD   = 2'd2;
   localparam logic [1:0] OP_WR   = 2'd3;

   localparam logic [2:0] SEL_PMAP0 = 3'd0;
   localparam logic [2:0] SEL_PMAP1 = 3'd1;
   localparam logic [2:0] SEL_SMAP  = 3'd2;
   localparam logic [2:0] SEL_CTX   = 3'd3;

   typedef struct packed {
      logic [2:0]  test;
      logic [1:0]  op;
      logic [23:1] va;
      logic [2:0]  fc;
      logic        wr;
      logic        uds;
      logic        lds;
      logic [15:0] wdata;
      logic [15:0] exp_rd;
      logic [11:0] exp_ppn;
      logic [2:0]  exp_type;
      logic        exp_perr;
      logic        exp_inv;
   } entry_t;

   logic        AS;
   logic        P_RESET_n;
   logic        xlat_strobe;
   logic        reg_strobe;
   logic        write;
   logic [23:1] va;
   logic [2:0]  fc;
   logic        uds;
   logic        lds;
   logic [15:0] wdata;
   logic [15:0] rdata;
   logic        rd_valid;
   logic        xlat_valid;
   logic [11:0] phys_page;
   logic [2:0]  pg_type;
   logic        prot_err;
   logic        page_invalid;

   // Reference copy of the maps and context registers
   logic [7:0]  smap_m [4096];
   logic [15:0] pm0_m [4096];
   logic [15:0] pm1_m [4096];
   logic [2:0]  ctx_u_m;
   logic [2:0]  ctx_s_m;

   entry_t      tbl [$];
   entry_t      inflight [$];
   logic [31:0] rng;
   logic [2:0]  build_test;
   logic [2:0]  cur_test;
   logic        table_ready;
   int          err_count;
   int          check_count;
   int          test_errs [8];
   int          test_checks [8];

   sun2_mmu dut_i (
      .AS(AS), .P_RESET_n(P_RESET_n),
      .xlat_strobe(xlat_strobe), .reg_strobe(reg_strobe), .write(write),
      .va(va), .fc(fc), .uds(uds), .lds(lds), .wdata(wdata),
      .rdata(rdata), .rd_valid(rd_valid), .xlat_valid(xlat_valid),
      .phys_page(phys_page), .pg_type(pg_type),
      .prot_err(prot_err), .page_invalid(page_invalid)
   );

   initial AS = 1'b0;
   always #50 AS = ~AS;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic string test_name(input logic [2:0] id);
      case (id)
         3'd1:    return "reset and context registers";
         3'd2:    return "segment and page map access";
         3'd3:    return "back-to-back translation";
         3'd4:    return "protection and valid";
         3'd5:    return "accessed and modified bits";
         default: return "setup";
      endcase
   endfunction

   function automatic logic [23:1] make_va(input logic [8:0] seg, input logic [3:0] page,
                                           input logic [2:0] sel);
      return {seg, page, 7'b0, sel};
   endfunction

   // Word 0 from the top: valid, prot sr sw sx ur uw ux, type, acc, mod, 4 spare
   function automatic logic [15:0] pte0(input logic v, input logic [5:0] prot,
                                        input logic [2:0] ty);
      return {v, prot, ty, 6'b000000};
   endfunction

   // ------------------------------------------------------------
   // Table building with expected values from the model
   // ------------------------------------------------------------

   task automatic add_op(input logic [1:0] op, input logic [23:1] a, input logic [2:0] f,
                         input logic wr, input logic ub, input logic lb,
                         input logic [15:0] d);
      entry_t      e;
      logic [2:0]  sel;
      logic [2:0]  ctx;
      logic [11:0] idx;
      logic [15:0] w0;
      int          kind;
      int          pbit;
      e = '0;
      e.test = build_test;
      e.op = op;
      e.va = a;
      e.fc = f;
      e.wr = wr;
      e.uds = ub;
      e.lds = lb;
      e.wdata = d;
      sel = a[3:1];
      ctx = (op == OP_XLAT && f[2]) ? ctx_s_m : ctx_u_m;
      idx = {smap_m[{ctx, a[23:15]}], a[14:11]};
      if (op == OP_WR)
      begin
         case (sel)
            SEL_CTX:
            begin
               if (lb)
                  ctx_u_m = d[2:0];
               if (ub)
                  ctx_s_m = d[10:8];
            end
            SEL_SMAP:
               if (lb)
                  smap_m[{ctx_u_m, a[23:15]}] = d[7:0];
            SEL_PMAP0:
            begin
               if (lb)
                  pm0_m[idx][7:0] = d[7:0];
               if (ub)
                  pm0_m[idx][15:8] = d[15:8];
            end
            SEL_PMAP1:
            begin
               if (lb)
                  pm1_m[idx][7:0] = d[7:0];
               if (ub)
                  pm1_m[idx][15:8] = d[15:8];
            end
            default: ;
         endcase
      end
      else if (op == OP_RD)
      begin
         case (sel)
            SEL_PMAP0: e.exp_rd = pm0_m[idx];
            SEL_PMAP1: e.exp_rd = pm1_m[idx];
            SEL_SMAP:  e.exp_rd = {8'h00, smap_m[{ctx_u_m, a[23:15]}]};
            SEL_CTX:   e.exp_rd = {5'b0, ctx_s_m, 5'b0, ctx_u_m};
            default:   e.exp_rd = 16'h0000;
         endcase
      end
      else if (op == OP_XLAT)
      begin
         w0 = pm0_m[idx];
         kind = f[1] ? 2 : (wr ? 1 : 0);
         pbit = (f[2] ? 14 : 11) - kind;
         e.exp_ppn = pm1_m[idx][11:0];
         e.exp_type = w0[8:6];
         e.exp_perr = !w0[pbit];
         e.exp_inv = !w0[15];
         if (w0[15] && w0[pbit])
         begin
            pm0_m[idx][5] = 1'b1;
            if (kind == 1)
               pm0_m[idx][4] = 1'b1;
         end
      end
      tbl.push_back(e);
   endtask

   task automatic reg_wr(input logic [2:0] sel, input logic [8:0] seg, input logic [3:0] page,
                         input logic ub, input logic lb, input logic [15:0] d);
      add_op(OP_WR, make_va(seg, page, sel), 3'd3, 1'b1, ub, lb, d);
   endtask

   task automatic reg_rd(input logic [2:0] sel, input logic [8:0] seg, input logic [3:0] page);
      add_op(OP_RD, make_va(seg, page, sel), 3'd3, 1'b0, 1'b1, 1'b1, 16'h0000);
   endtask

   task automatic xlat(input logic [8:0] seg, input logic [3:0] page, input logic [2:0] f,
                       input logic wr);
      add_op(OP_XLAT, make_va(seg, page, 3'd0), f, wr, 1'b1, 1'b1, 16'h0000);
   endtask

   task automatic idle(input int n);
      repeat (n)
         add_op(OP_IDLE, 23'h0, 3'd0, 1'b0, 1'b0, 1'b0, 16'h0000);
   endtask

   task automatic build_table();
      logic [8:0] seg;
      logic [3:0] page;
      logic [5:0] bitm;
      logic [2:0] fcv;
      rng = 32'heb9ec111;
      ctx_u_m = 3'd0;
      ctx_s_m = 3'd0;
      build_test = 3'd1;
      reg_rd(SEL_CTX, 9'h0, 4'h0);
      reg_wr(SEL_CTX, 9'h0, 4'h0, 1'b0, 1'b1, 16'h0705);
      reg_rd(SEL_CTX, 9'h0, 4'h0);
      reg_wr(SEL_CTX, 9'h0, 4'h0, 1'b1, 1'b0, 16'h0602);
      reg_rd(SEL_CTX, 9'h0, 4'h0);
      reg_wr(SEL_CTX, 9'h0, 4'h0, 1'b1, 1'b1, 16'h0301);
      reg_rd(SEL_CTX, 9'h0, 4'h0);
      reg_rd(3'd6, 9'h0, 4'h0);
      build_test = 3'd2;
      seg = 9'h0;
      page = 4'h0;
      for (int i = 0; i < 3; i++)
      begin
         seg = 9'(16 + i * 65);
         page = 4'(i * 5);
         reg_wr(SEL_CTX, 9'h0, 4'h0, 1'b0, 1'b1, 16'(i + 1));
         reg_wr(SEL_SMAP, seg, page, 1'b0, 1'b1, {8'hA5, 8'(33 + i)});
         reg_rd(SEL_SMAP, seg, page);
         rng = xorshift(rng);
         reg_wr(SEL_PMAP0, seg, page, 1'b1, 1'b1, rng[15:0]);
         reg_wr(SEL_PMAP1, seg, page, 1'b1, 1'b1, rng[31:16]);
         rng = xorshift(rng);
         reg_wr(SEL_PMAP0, seg, page, 1'b1, 1'b0, rng[15:0]);
         reg_wr(SEL_PMAP1, seg, page, 1'b0, 1'b1, rng[31:16]);
         reg_rd(SEL_PMAP0, seg, page);
         reg_rd(SEL_PMAP1, seg, page);
      end
      // High byte alone leaves a segment entry as it was
      reg_wr(SEL_SMAP, seg, page, 1'b1, 1'b0, 16'h7E7E);
      reg_rd(SEL_SMAP, seg, page);
      build_test = 3'd3;
      for (int c = 0; c < 4; c++)
      begin
         reg_wr(SEL_CTX, 9'h0, 4'h0, 1'b0, 1'b1, 16'(c));
         reg_wr(SEL_SMAP, 9'h155, 4'h0, 1'b0, 1'b1, 16'(16 + c));
         for (int p = 0; p < 4; p++)
         begin
            rng = xorshift(rng);
            reg_wr(SEL_PMAP0, 9'h155, 4'(p), 1'b1, 1'b1, pte0(1'b1, 6'h3F, rng[2:0]));
            reg_wr(SEL_PMAP1, 9'h155, 4'(p), 1'b1, 1'b1, rng[31:16]);
         end
      end
      reg_wr(SEL_CTX, 9'h0, 4'h0, 1'b1, 1'b1, 16'h0201);
      for (int p = 0; p < 8; p++)
         xlat(9'h155, 4'(p / 2), p[0] ? 3'd5 : 3'd1, (p % 3) == 0);
      reg_wr(SEL_CTX, 9'h0, 4'h0, 1'b1, 1'b1, 16'h0003);
      for (int p = 0; p < 8; p++)
         xlat(9'h155, 4'(p / 2), p[0] ? 3'd5 : 3'd1, (p % 3) == 1);
      build_test = 3'd4;
      reg_wr(SEL_CTX, 9'h0, 4'h0, 1'b1, 1'b1, 16'h0505);
      reg_wr(SEL_SMAP, 9'h0AB, 4'h0, 1'b0, 1'b1, 16'h0040);
      // Kinds 0..2 supervisor r/w/x, 3..5 user r/w/x
      for (int k = 0; k < 6; k++)
      begin
         bitm = 6'b100000 >> k;
         rng = xorshift(rng);
         reg_wr(SEL_PMAP0, 9'h0AB, 4'(2 * k), 1'b1, 1'b1,
                pte0(1'b1, rng[5:0] & ~bitm, rng[8:6]));
         reg_wr(SEL_PMAP1, 9'h0AB, 4'(2 * k), 1'b1, 1'b1, rng[31:16]);
         reg_wr(SEL_PMAP0, 9'h0AB, 4'(2 * k + 1), 1'b1, 1'b1,
                pte0(1'b1, rng[13:8] | bitm, rng[16:14]));
         reg_wr(SEL_PMAP1, 9'h0AB, 4'(2 * k + 1), 1'b1, 1'b1, rng[15:0]);
      end
      rng = xorshift(rng);
      reg_wr(SEL_PMAP0, 9'h0AB, 4'd12, 1'b1, 1'b1, pte0(1'b0, 6'h3F, rng[2:0]));
      reg_wr(SEL_PMAP1, 9'h0AB, 4'd12, 1'b1, 1'b1, rng[31:16]);
      for (int k = 0; k < 6; k++)
      begin
         fcv = {k < 3, (k % 3) == 2, (k % 3) != 2};
         xlat(9'h0AB, 4'(2 * k), fcv, (k % 3) == 1);
         xlat(9'h0AB, 4'(2 * k + 1), fcv, (k % 3) == 1);
      end
      xlat(9'h0AB, 4'd12, 3'd1, 1'b0);
      build_test = 3'd5;
      idle(3);
      for (int p = 0; p < 13; p++)
         reg_rd(SEL_PMAP0, 9'h0AB, 4'(p));
   endtask

   // ------------------------------------------------------------
   // Driving and checking
   // ------------------------------------------------------------

   task automatic drive(input entry_t e);
      xlat_strobe = (e.op == OP_XLAT);
      reg_strobe = (e.op == OP_RD) || (e.op == OP_WR);
      write = e.wr;
      va = e.va;
      fc = e.fc;
      uds = e.uds;
      lds = e.lds;
      wdata = e.wdata;
   endtask

   task automatic report_mismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("Fail at %0t: %s is %0h, expected %0h (test %0d)",
               $time, what, got, exp, cur_test);
      err_count++;
      test_errs[cur_test]++;
   endtask

   task automatic finish_test(input logic [2:0] id);
      $display("Test %0d, %s: %0d checks, %0d errors",
               id, test_name(id), test_checks[id], test_errs[id]);
   endtask

   task automatic check_result(input entry_t e);
      logic exp_rdv;
      logic exp_xv;
      exp_rdv = (e.op == OP_RD);
      exp_xv = (e.op == OP_XLAT);
      if (e.test != cur_test)
      begin
         if (cur_test != 3'd0)
            finish_test(cur_test);
         cur_test = e.test;
      end
      check_count++;
      test_checks[cur_test]++;
      if (rd_valid !== exp_rdv)
         report_mismatch("rd_valid", 32'(rd_valid), 32'(exp_rdv));
      if (xlat_valid !== exp_xv)
         report_mismatch("xlat_valid", 32'(xlat_valid), 32'(exp_xv));
      if (exp_rdv && rdata !== e.exp_rd)
         report_mismatch("rdata", 32'(rdata), 32'(e.exp_rd));
      if (exp_xv && phys_page !== e.exp_ppn)
         report_mismatch("phys_page", 32'(phys_page), 32'(e.exp_ppn));
      if (exp_xv && pg_type !== e.exp_type)
         report_mismatch("pg_type", 32'(pg_type), 32'(e.exp_type));
      if (prot_err !== (exp_xv & e.exp_perr))
         report_mismatch("prot_err", 32'(prot_err), 32'(exp_xv & e.exp_perr));
      if (page_invalid !== (exp_xv & e.exp_inv))
         report_mismatch("page_invalid", 32'(page_invalid), 32'(exp_xv & e.exp_inv));
   endtask

   initial
   begin
      entry_t idle_e;
      idle_e = '0;
      P_RESET_n = 1'b0;
      xlat_strobe = 1'b0;
      reg_strobe = 1'b0;
      write = 1'b0;
      va = '0;
      fc = 3'd0;
      uds = 1'b0;
      lds = 1'b0;
      wdata = 16'h0000;
      err_count = 0;
      check_count = 0;
      cur_test = 3'd0;
      table_ready = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (5) @(posedge AS);
      #5 P_RESET_n = 1'b1;
      if ({rd_valid, xlat_valid, prot_err, page_invalid} !== 4'b0000)
         report_mismatch("outputs after reset", 32'({rd_valid, xlat_valid, prot_err,
                         page_invalid}), 32'd0);
      // Result of an entry shows four edges after it is driven
      for (int i = 0; i < tbl.size() + 4; i++)
      begin
         @(posedge AS);
         #5;
         if (inflight.size() == 4)
            check_result(inflight.pop_front());
         drive((i < tbl.size()) ? tbl[i] : idle_e);
         inflight.push_back((i < tbl.size()) ? tbl[i] : idle_e);
      end
      finish_test(cur_test);
      $display("Summary: %0d checks, %0d errors", check_count, err_count);
      if (err_count == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

   // Watchdog
   initial
   begin
      int limit_ns;
      wait (table_ready);
      limit_ns = (tbl.size() + 20) * 100;
      #(limit_ns);
      $display("Watchdog expired before the stimulus table finished");
      $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- sun2_mmu.sv
// Results three clocks after each strobe; no back-pressure, xlat and reg strobes never together
`timescale 1ns/1ps
`default_nettype none

module sun2_mmu
   import mmu_cfg_pkg::*;
   import mmu_types_pkg::*;
#(
   parameter int CTX_W  = mmu_cfg_pkg::CTX_W,
   parameter int PMEG_W = mmu_cfg_pkg::PMEG_W,
   parameter int PPN_W  = mmu_cfg_pkg::PPN_W
)
(
   input  wire logic              AS,
   input  wire logic              P_RESET_n,
   input  wire logic              xlat_strobe,
   input  wire logic              reg_strobe,
   input  wire logic              write,
   input  wire logic [23:1]       va,
   input  wire logic [2:0]        fc,
   input  wire logic              uds,
   input  wire logic              lds,
   input  wire logic [WORD_W-1:0] wdata,
   output logic [WORD_W-1:0]      rdata,
   output logic                   rd_valid,
   output logic                   xlat_valid,
   output logic [PPN_W-1:0]       phys_page,
   output logic [2:0]             pg_type,
   output logic                   prot_err,
   output logic                   page_invalid
);

   logic              s2_valid;
   logic              s2_is_reg;
   access_kind_e      s2_kind;
   logic              s2_super;
   logic              s2_write;
   reg_sel_e          s2_reg_sel;
   logic [WORD_W-1:0] smap_rdata;
   logic [WORD_W-1:0] ctx_rdata;

   pmap_bus_if #(.AW(PMEG_W + PAGE_VA_W), .W(WORD_W)) pm_bus [N_PMAP_WORDS] ();

   mmu_front #(.CTX_W(CTX_W), .PMEG_W(PMEG_W)) front_i (
      .AS(AS), .P_RESET_n(P_RESET_n),
      .xlat_strobe(xlat_strobe), .reg_strobe(reg_strobe), .write(write),
      .va(va), .fc(fc), .uds(uds), .lds(lds), .wdata(wdata),
      .pm(pm_bus),
      .s2_valid(s2_valid), .s2_is_reg(s2_is_reg), .s2_kind(s2_kind),
      .s2_super(s2_super), .s2_write(s2_write), .s2_reg_sel(s2_reg_sel),
      .smap_rdata(smap_rdata), .ctx_rdata(ctx_rdata)
   );

   // Word 0 flags, word 1 physical page
   for (genvar i = 0; i < N_PMAP_WORDS; i++)
   begin : g_bank
      pmap_word_bank #(.AW(PMEG_W + PAGE_VA_W), .W(WORD_W)) bank_i (
         .AS(AS),
         .bus(pm_bus[i])
      );
   end

   mmu_check #(.PMEG_W(PMEG_W), .PPN_W(PPN_W)) check_i (
      .AS(AS), .P_RESET_n(P_RESET_n),
      .pm(pm_bus),
      .s2_valid(s2_valid), .s2_is_reg(s2_is_reg), .s2_kind(s2_kind),
      .s2_super(s2_super), .s2_write(s2_write), .s2_reg_sel(s2_reg_sel),
      .smap_rdata(smap_rdata), .ctx_rdata(ctx_rdata),
      .rdata(rdata), .rd_valid(rd_valid), .xlat_valid(xlat_valid),
      .phys_page(phys_page), .pg_type(pg_type),
      .prot_err(prot_err), .page_invalid(page_invalid)
   );

endmodule

`default_nettype wire

//--- mmu_check.sv
// Faults are reported, not blocked; statistics are set in page-map word 0 only
`timescale 1ns/1ps
`default_nettype none

module mmu_check
   import mmu_cfg_pkg::*;
   import mmu_types_pkg::*;
#(
   parameter int PMEG_W = mmu_cfg_pkg::PMEG_W,
   parameter int PPN_W  = mmu_cfg_pkg::PPN_W
)
(
   input  wire logic              AS,
   input  wire logic              P_RESET_n,
   pmap_bus_if.check              pm [N_PMAP_WORDS],
   input  wire logic              s2_valid,
   input  wire logic              s2_is_reg,
   input  wire access_kind_e      s2_kind,
   input  wire logic              s2_super,
   input  wire logic              s2_write,
   input  wire reg_sel_e          s2_reg_sel,
   input  wire logic [WORD_W-1:0] smap_rdata,
   input  wire logic [WORD_W-1:0] ctx_rdata,
   output logic [WORD_W-1:0]      rdata,
   output logic                   rd_valid,
   output logic                   xlat_valid,
   output logic [PPN_W-1:0]       phys_page,
   output logic [2:0]             pg_type,
   output logic                   prot_err,
   output logic                   page_invalid
);

   pmap0_word_u                   w0;
   pmap0_word_u                   stat_mask;
   logic                          is_xlat;
   logic                          prot_ok;
   logic                          stat_set;
   logic [PMEG_W+PAGE_VA_W-1:0]   set_addr_q;
   logic [WORD_W-1:0]             rd_word;

   assign w0.raw  = pm[0].rdata;
   assign is_xlat = s2_valid & ~s2_is_reg;

   // ------------------------------------------------------------
   // Protection and statistics
   // ------------------------------------------------------------

   always_comb
   begin
      case (s2_kind)
         KIND_WRITE: prot_ok = s2_super ? w0.f.prot[4] : w0.f.prot[1];
         KIND_EXEC:  prot_ok = s2_super ? w0.f.prot[3] : w0.f.prot[0];
         default:    prot_ok = s2_super ? w0.f.prot[5] : w0.f.prot[2];
      endcase
   end

   always_comb
   begin
      stat_mask.raw   = '0;
      stat_mask.f.acc = 1'b1;
      stat_mask.f.mod = (s2_kind == KIND_WRITE);
   end

   assign stat_set = is_xlat & w0.f.valid & prot_ok;

   // Entry address of the read now on rdata
   always_ff @(posedge AS)
   begin
      set_addr_q <= pm[0].addr;
   end

   for (genvar i = 0; i < N_PMAP_WORDS; i++)
   begin : g_set
      assign pm[i].set_en   = (i == 0) ? stat_set : 1'b0;
      assign pm[i].set_addr = set_addr_q;
      assign pm[i].set_mask = (i == 0) ? stat_mask.raw : '0;
   end

   // ------------------------------------------------------------
   // Register read data and result stage
   // ------------------------------------------------------------

   always_comb
   begin
      case (s2_reg_sel)
         REG_PMAP0: rd_word = w0.raw;
         REG_PMAP1: rd_word = pm[1].rdata;
         REG_SMAP:  rd_word = smap_rdata;
         REG_CTX:   rd_word = ctx_rdata;
         default:   rd_word = '0;
      endcase
   end

   always_ff @(posedge AS or negedge P_RESET_n)
   begin
      if (!P_RESET_n)
      begin
         rd_valid     <= 1'b0;
         xlat_valid   <= 1'b0;
         prot_err     <= 1'b0;
         page_invalid <= 1'b0;
      end
      else
      begin
         rd_valid     <= s2_valid & s2_is_reg & ~s2_write;
         xlat_valid   <= is_xlat;
         prot_err     <= is_xlat & ~prot_ok;
         page_invalid <= is_xlat & ~w0.f.valid;
      end
   end

   always_ff @(posedge AS)
   begin
      rdata     <= rd_word;
      phys_page <= pm[1].rdata[PPN_W-1:0];
      pg_type   <= w0.f.pg_type;
   end

endmodule

`default_nettype wire

//--- mmu_front.sv
// Context and segment-map writes use lds only for fields up to 8 bits; strobes must not overlap
`timescale 1ns/1ps
`default_nettype none

module mmu_front
   import mmu_cfg_pkg::*;
   import mmu_types_pkg::*;
#(
   parameter int CTX_W  = mmu_cfg_pkg::CTX_W,
   parameter int PMEG_W = mmu_cfg_pkg::PMEG_W
)
(
   input  wire logic              AS,
   input  wire logic              P_RESET_n,
   input  wire logic              xlat_strobe,
   input  wire logic              reg_strobe,
   input  wire logic              write,
   input  wire logic [23:1]       va,
   input  wire logic [2:0]        fc,
   input  wire logic              uds,
   input  wire logic              lds,
   input  wire logic [WORD_W-1:0] wdata,
   pmap_bus_if.front              pm [N_PMAP_WORDS],
   output logic                   s2_valid,
   output logic                   s2_is_reg,
   output access_kind_e           s2_kind,
   output logic                   s2_super,
   output logic                   s2_write,
   output reg_sel_e               s2_reg_sel,
   output logic [WORD_W-1:0]      smap_rdata,
   output logic [WORD_W-1:0]      ctx_rdata
);

   localparam int SEG_AW = CTX_W + SEG_VA_W;

   logic [CTX_W-1:0]     ctx_u;
   logic [CTX_W-1:0]     ctx_s;
   logic [PMEG_W-1:0]    smap [2**SEG_AW];
   access_kind_e         kind_in;
   logic [WORD_W-1:0]    ctx_word;

   logic                 st1_valid;
   logic                 st1_is_reg;
   logic                 st1_write;
   logic                 st1_super;
   access_kind_e         st1_kind;
   reg_sel_e             st1_sel;
   logic [SEG_VA_W-1:0]  st1_seg;
   logic [PAGE_VA_W-1:0] st1_page;
   logic                 st1_uds;
   logic                 st1_lds;
   logic [WORD_W-1:0]    st1_wdata;
   logic [CTX_W-1:0]     ctx_sel;
   logic [SEG_AW-1:0]    smap_a;
   logic                 st1_wr;

   logic                 st2_valid;
   logic                 st2_is_reg;
   logic                 st2_write;
   logic                 st2_super;
   access_kind_e         st2_kind;
   reg_sel_e             st2_sel;
   logic [PAGE_VA_W-1:0] st2_page;
   logic                 st2_uds;
   logic                 st2_lds;
   logic [WORD_W-1:0]    st2_wdata;
   logic [PMEG_W-1:0]    pmeg_q;
   logic [WORD_W-1:0]    ctx_word_q;
   logic                 st2_wr;

   always_comb
   begin
      if (fc[1])
         kind_in = KIND_EXEC;
      else if (write)
         kind_in = KIND_WRITE;
      else
         kind_in = KIND_READ;
   end

   always_comb
   begin
      ctx_word = '0;
      ctx_word[CTX_W-1:0] = ctx_u;
      ctx_word[8 +: CTX_W] = ctx_s;
   end

   // ------------------------------------------------------------
   // Stage 1: latch request, segment map read
   // ------------------------------------------------------------

   always_ff @(posedge AS or negedge P_RESET_n)
   begin
      if (!P_RESET_n)
      begin
         st1_valid <= 1'b0;
         st2_valid <= 1'b0;
         s2_valid  <= 1'b0;
      end
      else
      begin
         st1_valid <= xlat_strobe | reg_strobe;
         st2_valid <= st1_valid;
         s2_valid  <= st2_valid;
      end
   end

   always_ff @(posedge AS)
   begin
      st1_is_reg <= reg_strobe;
      st1_write  <= write;
      st1_super  <= fc[2] & ~reg_strobe;
      st1_kind   <= kind_in;
      st1_sel    <= reg_sel_e'(va[3:1]);
      st1_seg    <= va[23:15];
      st1_page   <= va[14:11];
      st1_uds    <= uds;
      st1_lds    <= lds;
      st1_wdata  <= wdata;
   end

   // Register access always runs in the user context
   assign ctx_sel = st1_super ? ctx_s : ctx_u;
   assign smap_a  = {ctx_sel, st1_seg};
   assign st1_wr  = st1_valid & st1_is_reg & st1_write;

   always_ff @(posedge AS or negedge P_RESET_n)
   begin
      if (!P_RESET_n)
      begin
         ctx_u <= '0;
         ctx_s <= '0;
      end
      else if (st1_wr && st1_sel == REG_CTX)
      begin
         if (st1_lds)
            ctx_u <= st1_wdata[CTX_W-1:0];
         if (st1_uds)
            ctx_s <= st1_wdata[8 +: CTX_W];
      end
   end

   always_ff @(posedge AS)
   begin
      if (st1_wr && st1_sel == REG_SMAP && st1_lds)
         smap[smap_a] <= st1_wdata[PMEG_W-1:0];
      pmeg_q     <= smap[smap_a];
      ctx_word_q <= ctx_word;
   end

   // ------------------------------------------------------------
   // Stage 2: page-map address and register byte writes
   // ------------------------------------------------------------

   always_ff @(posedge AS)
   begin
      st2_is_reg <= st1_is_reg;
      st2_write  <= st1_write;
      st2_super  <= st1_super;
      st2_kind   <= st1_kind;
      st2_sel    <= st1_sel;
      st2_page   <= st1_page;
      st2_uds    <= st1_uds;
      st2_lds    <= st1_lds;
      st2_wdata  <= st1_wdata;
   end

   assign st2_wr = st2_valid & st2_is_reg & st2_write;

   // Bank i answers register select code i
   for (genvar i = 0; i < N_PMAP_WORDS; i++)
   begin : g_bus
      assign pm[i].rd_en = st2_valid;
      assign pm[i].addr  = {pmeg_q, st2_page};
      assign pm[i].wdata = st2_wdata;
      assign pm[i].be    = (st2_wr && st2_sel == reg_sel_e'(i)) ? {st2_uds, st2_lds} : 2'b00;
   end

   // Travels with the bank read data into the checker
   always_ff @(posedge AS)
   begin
      s2_is_reg  <= st2_is_reg;
      s2_kind    <= st2_kind;
      s2_super   <= st2_super;
      s2_write   <= st2_write;
      s2_reg_sel <= st2_sel;
      smap_rdata <= WORD_W'(pmeg_q);
      ctx_rdata  <= ctx_word_q;
   end

   a_strobe_excl: assert property (@(posedge AS) disable iff (!P_RESET_n)
      !(xlat_strobe && reg_strobe));

   a_reg_write_byte: assert property (@(posedge AS) disable iff (!P_RESET_n)
      reg_strobe && write |-> uds || lds);

endmodule

`default_nettype wire

//--- pmap_word_bank.sv
// Contents undefined until written; a byte write and a bit set must not hit one entry together
`timescale 1ns/1ps
`default_nettype none

module pmap_word_bank #(
   parameter int AW = 12,
   parameter int W  = 16
)
(
   input  wire logic AS,
   pmap_bus_if.bank  bus
);

   localparam int HB = W / 2;

   logic [W-1:0] mem [2**AW];

   // Read returns the word as it was before this edge
   always_ff @(posedge AS)
   begin
      if (bus.be[0])
         mem[bus.addr][HB-1:0] <= bus.wdata[HB-1:0];
      if (bus.be[1])
         mem[bus.addr][W-1:HB] <= bus.wdata[W-1:HB];
      if (bus.set_en)
         mem[bus.set_addr] <= mem[bus.set_addr] | bus.set_mask;
      if (bus.rd_en)
         bus.rdata <= mem[bus.addr];
   end

   // Register write from the front end against a statistics set from the checker
   a_no_write_set_clash: assert property (@(posedge AS)
      bus.set_en |-> !((|bus.be) && bus.set_addr == bus.addr));

endmodule

`default_nettype wire

//--- pmap_bus_if.sv
// One page-map word bank; byte enables assume a 16-bit word split into two bytes
`timescale 1ns/1ps
`default_nettype none

interface pmap_bus_if #(
   parameter int AW = 12,
   parameter int W  = 16
);

   // Stage-2 read and byte write
   logic          rd_en;
   logic [AW-1:0] addr;
   logic [W-1:0]  wdata;
   logic [1:0]    be;
   logic [W-1:0]  rdata;

   // Statistics OR-set from the checker
   logic          set_en;
   logic [AW-1:0] set_addr;
   logic [W-1:0]  set_mask;

   modport front (output rd_en, addr, wdata, be);

   modport bank (input rd_en, addr, wdata, be, set_en, set_addr, set_mask,
                 output rdata);

   modport check (input rdata, addr,
                  output set_en, set_addr, set_mask);

endinterface

`default_nettype wire

//--- mmu_types_pkg.sv
// Word 0 layout is fixed at 16 bits; register codes other than the four listed read as zero
`default_nettype none

package mmu_types_pkg;

   import mmu_cfg_pkg::*;

   // ------------------------------------------------------------
   // Page-map entry, word 0
   // ------------------------------------------------------------

   // prot order: sup r/w/x then user r/w/x
   typedef struct packed {
      logic       valid;
      logic [5:0] prot;
      logic [2:0] pg_type;
      logic       acc;
      logic       mod;
      logic [3:0] unused;
   } pmap0_fields_t;

   // Fields for the checker, raw word for the register bus
   typedef union packed {
      pmap0_fields_t     f;
      logic [WORD_W-1:0] raw;
   } pmap0_word_u;

   // ------------------------------------------------------------
   // Register select, va[3:1]
   // ------------------------------------------------------------

   typedef enum logic [2:0] {
      REG_PMAP0 = 3'd0,
      REG_PMAP1 = 3'd1,
      REG_SMAP  = 3'd2,
      REG_CTX   = 3'd3
   } reg_sel_e;

   // Access kind carried down the pipe
   typedef enum logic [1:0] {
      KIND_READ  = 2'd0,
      KIND_WRITE = 2'd1,
      KIND_EXEC  = 2'd2
   } access_kind_e;

endpackage

`default_nettype wire

//--- mmu_cfg_pkg.sv
// Default sizes only; the top level may widen context and pmeg up to 8 bits each
`default_nettype none

package mmu_cfg_pkg;

   // ------------------------------------------------------------
   // Address fields and map geometry
   // ------------------------------------------------------------

   localparam int CTX_W        = 3;
   localparam int SEG_VA_W     = 9;     // va[23:15]
   localparam int PMEG_W       = 8;
   localparam int PAGE_VA_W    = 4;     // va[14:11]
   localparam int PPN_W        = 12;

   // Bus word and page-map entry layout
   localparam int WORD_W       = 16;
   localparam int N_PMAP_WORDS = 2;

   // Map index widths at the default sizes
   localparam int SMAP_AW      = CTX_W + SEG_VA_W;
   localparam int PMAP_AW      = PMEG_W + PAGE_VA_W;

endpackage

`default_nettype wire
